//--- design/contactDetect.sv
`timescale 1ns/10ps

module contactDetect
	import doodlePkg::*;
(
	input coordT posX,
	input coordT posY,
	input platformT [NumPlatforms-1:0] platforms,
	input platformT springPos,
	input platformT rocketPos,
	output contactE contact
);

	// hit when the base is inside the object's vertical band and the spans overlap
	function automatic logic hitTest(input platformT obj, input int halfX, input int halfY,
		input coordT figX, input coordT figY);
		int baseY;
		int objX;
		int objY;
		baseY = int'(figY) + DoodleSize;
		objX = int'(obj.x);
		objY = int'(obj.y);
		hitTest = obj.active
			&& (baseY >= objY - halfY) && (baseY <= objY + halfY)
			&& (objX + halfX >= int'(figX) - DoodleSize)
			&& (objX - halfX <= int'(figX) + DoodleSize);
	endfunction

	logic platHit;
	logic springHit;
	logic rocketHit;

	always_comb
	begin
		platHit = 1'b0;
		for (int i = 0; i < NumPlatforms; i++)
			platHit = platHit | hitTest(platforms[i], PlatHalfX, PlatHalfY, posX, posY);
		springHit = hitTest(springPos, SpringHalf, SpringHalf, posX, posY);
		rocketHit = hitTest(rocketPos, RocketHalf, RocketHalf, posX, posY);
	end

	// rocket over spring over platform
	always_comb
	begin
		if (rocketHit)
			contact = cRocket;
		else if (springHit)
			contact = cSpring;
		else if (platHit)
			contact = cPlatform;
		else
			contact = cNone;
	end

endmodule

//--- design/doodleCore.sv
`timescale 1ns/10ps

module doodleCore
	import doodlePkg::*;
(
	input logic Reset,          // clock
	input logic frameClk,       // async reset
	input logic [7:0] keycode,
	input logic frameTick,
	input platformT [NumPlatforms-1:0] platforms,
	input platformT springPos,
	input platformT rocketPos,
	input logic renderBusy,
	output frameRecT frameOut,
	output logic frameValid,
	output logic [19:0] score,
	output logic gameOver
);

	coordT posX;
	coordT posY;
	contactE contact;
	logic pushValid;
	frameRecT pushRec;
	logic creditReturn;
	frameRecT popRec;
	logic notEmpty;
	logic popReady;

	contactDetect contact0 (.posX(posX), .posY(posY), .platforms(platforms),
		.springPos(springPos), .rocketPos(rocketPos), .contact(contact));

	jumpPhysics physics0 (.Reset(Reset), .frameClk(frameClk), .frameTick(frameTick),
		.keycode(keycode), .contact(contact), .posX(posX), .posY(posY),
		.pushValid(pushValid), .pushRec(pushRec), .creditReturn(creditReturn));

	// credit loop between physics and buffer
	frameFifo fifo0 (.Reset(Reset), .frameClk(frameClk), .pushValid(pushValid),
		.pushRec(pushRec), .popReady(popReady), .popRec(popRec), .notEmpty(notEmpty),
		.creditReturn(creditReturn));

	scoreKeeper score0 (.Reset(Reset), .frameClk(frameClk), .notEmpty(notEmpty),
		.popRec(popRec), .renderBusy(renderBusy), .popReady(popReady),
		.frameOut(frameOut), .frameValid(frameValid), .score(score),
		.gameOver(gameOver));

endmodule

//--- design/doodlePkg.sv
package doodlePkg;

	// screen and figure geometry
	localparam int ScreenXMax = 639;
	localparam int FloorY = 479;
	localparam int WrapMargin = 25;
	localparam int DoodleSize = 16;     // half-size of the figure
	localparam int PlatHalfX = 20;
	localparam int PlatHalfY = 4;
	localparam int SpringHalf = 6;
	localparam int RocketHalf = 10;
	localparam int NumPlatforms = 8;

	localparam int StartX = 330;
	localparam int StartY = 100;
	localparam int ScoreLine = 240;    // scoring starts above this line

	// physics step sizes in pixels
	localparam int Gravity = 1;
	localparam int MaxFall = 8;
	localparam int PlatLaunch = 12;
	localparam int SpringLaunch = 20;
	localparam int RocketLaunch = 30;
	localparam int StepX = 4;

	localparam int OverScore = 256;

	// frame buffer and credit counter
	localparam int FifoDepth = 4;
	localparam int CreditW = $clog2(FifoDepth + 1);
	localparam int PtrW = $clog2(FifoDepth);

	// keyboard codes
	localparam int KeyLeftA = 4;
	localparam int KeyLeftB = 80;
	localparam int KeyRightA = 7;
	localparam int KeyRightB = 79;

	typedef logic [9:0] coordT;
	typedef logic signed [9:0] velT;     // negative is upward

	typedef struct packed {
		coordT x;
		coordT y;
		logic active;
	} platformT;

	typedef struct packed {
		coordT posX;
		coordT posY;
		velT velY;
	} frameRecT;

	typedef enum logic [1:0] {cNone, cPlatform, cSpring, cRocket} contactE;

	typedef enum logic [1:0] {mvNone, mvLeft, mvRight} moveE;

	typedef enum logic {ssPlaying, ssOver} scoreStateE;

endpackage

//--- design/frameFifo.sv
`timescale 1ns/10ps

module frameFifo
	import doodlePkg::*;
(
	input logic Reset,          // clock
	input logic frameClk,       // async reset
	input logic pushValid,
	input frameRecT pushRec,
	input logic popReady,
	output frameRecT popRec,
	output logic notEmpty,
	output logic creditReturn
);

	frameRecT mem [FifoDepth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CreditW-1:0] count;   // occupancy
	logic doPop;

	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		if (ptr == PtrW'(FifoDepth - 1))
			nextPtr = '0;
		else
			nextPtr = ptr + 1'b1;
	endfunction

	assign notEmpty = count != '0;
	assign doPop = popReady && notEmpty;
	assign popRec = mem[rdPtr];     // head is always visible

	always_ff @(posedge Reset)
	begin
		if (pushValid)
			mem[wrPtr] <= pushRec;
	end

	always_ff @(posedge Reset or posedge frameClk)
	begin
		if (frameClk)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (pushValid)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			count <= count + CreditW'(pushValid) - CreditW'(doPop);
			creditReturn <= doPop;    // one credit back per pop
		end
	end

	// credits upstream lag the pop, so a full buffer never sees a push
	noOverflow: assert property (@(posedge Reset) disable iff (frameClk)
		pushValid |-> count != CreditW'(FifoDepth));

endmodule

//--- design/jumpPhysics.sv
`timescale 1ns/10ps

module jumpPhysics
	import doodlePkg::*;
(
	input logic Reset,          // clock
	input logic frameClk,       // async reset, active high
	input logic frameTick,
	input logic [7:0] keycode,
	input contactE contact,
	output coordT posX,
	output coordT posY,
	output logic pushValid,
	output frameRecT pushRec,
	input logic creditReturn
);

	velT velY;
	logic [CreditW-1:0] credits;  // free buffer slots
	moveE move;
	int baseY;
	int velNext;
	int xMoved;
	coordT nextX;
	coordT nextY;

	function automatic int launchSpeed(input contactE kind);
		case (kind)
			cRocket: launchSpeed = RocketLaunch;
			cSpring: launchSpeed = SpringLaunch;
			default: launchSpeed = PlatLaunch;
		endcase
	endfunction

	always_comb
	begin
		case (keycode)
			KeyLeftA, KeyLeftB: move = mvLeft;
			KeyRightA, KeyRightB: move = mvRight;
			default: move = mvNone;
		endcase
	end

	// vertical step with launches only while not rising
	always_comb
	begin
		baseY = int'(posY) + DoodleSize;
		if (velY >= 0 && contact != cNone)
			velNext = -launchSpeed(contact);
		else if (velY >= 0 && baseY >= FloorY)
			velNext = -PlatLaunch;            // bounce off the ground
		else if (int'(velY) + Gravity > MaxFall)
			velNext = MaxFall;
		else
			velNext = int'(velY) + Gravity;
		nextY = coordT'(int'(posY) + velNext);
	end

	// horizontal step and side wrap
	always_comb
	begin
		case (move)
			mvLeft: xMoved = int'(posX) - StepX;
			mvRight: xMoved = int'(posX) + StepX;
			default: xMoved = int'(posX);
		endcase
		if (xMoved < WrapMargin)
			nextX = coordT'(ScreenXMax - WrapMargin);
		else if (xMoved > ScreenXMax - WrapMargin)
			nextX = coordT'(WrapMargin);
		else
			nextX = coordT'(xMoved);
	end

	// a tick without credit is dropped
	assign pushValid = frameTick && (credits != '0);
	assign pushRec = '{posX: nextX, posY: nextY, velY: velT'(velNext)};

	always_ff @(posedge Reset or posedge frameClk)
	begin
		if (frameClk)
		begin
			posX <= coordT'(StartX);
			posY <= coordT'(StartY);
			velY <= '0;
			credits <= CreditW'(FifoDepth);
		end
		else
		begin
			if (pushValid)
			begin
				posX <= nextX;
				posY <= nextY;
				velY <= velT'(velNext);
			end
			credits <= credits - CreditW'(pushValid) + CreditW'(creditReturn);
		end
	end

	// returned credits must match earlier pushes
	creditBound: assert property (@(posedge Reset) disable iff (frameClk)
		credits <= CreditW'(FifoDepth));

endmodule

//--- design/scoreKeeper.sv
`timescale 1ns/10ps

module scoreKeeper
	import doodlePkg::*;
(
	input logic Reset,          // clock
	input logic frameClk,       // async reset
	input logic notEmpty,
	input frameRecT popRec,
	input logic renderBusy,
	output logic popReady,
	output frameRecT frameOut,
	output logic frameValid,
	output logic [19:0] score,
	output logic gameOver
);

	scoreStateE state;
	coordT bestY;     // highest point reached so far
	logic atFloor;

	assign popReady = notEmpty && !renderBusy;
	assign atFloor = int'(popRec.posY) + DoodleSize >= FloorY;
	assign gameOver = state == ssOver;

	// record goes out to the renderer a cycle after the pop
	always_ff @(posedge Reset)
	begin
		if (popReady)
			frameOut <= popRec;
	end

	always_ff @(posedge Reset or posedge frameClk)
	begin
		if (frameClk)
		begin
			frameValid <= 1'b0;
			score <= '0;
			bestY <= coordT'(ScoreLine);
			state <= ssPlaying;
		end
		else
		begin
			frameValid <= popReady;
			if (popReady)
			begin
				// only new height counts
				if (popRec.posY < bestY)
				begin
					score <= score + 20'(bestY - popRec.posY);
					bestY <= popRec.posY;
				end
				if (state == ssPlaying && atFloor && score > 20'(OverScore))
					state <= ssOver;      // sticky until reset
			end
		end
	end

endmodule

//--- list.f
design/doodlePkg.sv
design/contactDetect.sv
design/jumpPhysics.sv
design/frameFifo.sv
design/scoreKeeper.sv
design/doodleCore.sv
tests/tbDoodleCore.sv

//--- run.sh
#!/bin/sh
# build and run the doodleCore testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbDoodleCore \
	-Mdir obj_dir -f list.f
out=$(./obj_dir/VtbDoodleCore)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

//--- tests/tbDoodleCore.sv
`timescale 1ns/10ps

module tbDoodleCore
	import doodlePkg::*;
();

	localparam int ClkPeriod = 100;
	localparam int TickGap = 4;        // cycles from one frame tick to the next
	localparam int DrainLimit = 40;
	localparam int TotalTicks = 1 + 60 + 120 + 220 + 80 + 40;
	localparam int WatchCycles = TotalTicks * TickGap + 6 * (8 + DrainLimit + 2) + 200;

	typedef struct packed {
		frameRecT rec;
		logic [19:0] score;
		logic over;
	} expectT;

	logic Reset;
	logic frameClk;
	logic [7:0] keycode;
	logic frameTick;
	platformT [NumPlatforms-1:0] platforms;
	platformT springPos;
	platformT rocketPos;
	logic renderBusy;
	frameRecT frameOut;
	logic frameValid;
	logic [19:0] score;
	logic gameOver;

	expectT expQ[$];
	expectT expHead;
	int expCount;
	int mX;
	int mY;
	int mV;
	int mCredits;      // credit count as seen from the renderer side
	int mScore;
	int mBest;
	logic mOver;
	int seed;
	int errors;
	int errorsBefore;
	int passCount;
	int failCount;

	doodleCore dut0 (.Reset(Reset), .frameClk(frameClk), .keycode(keycode),
		.frameTick(frameTick), .platforms(platforms), .springPos(springPos),
		.rocketPos(rocketPos), .renderBusy(renderBusy), .frameOut(frameOut),
		.frameValid(frameValid), .score(score), .gameOver(gameOver));

	initial
	begin
		Reset = 1'b0;
		forever
			#(ClkPeriod / 2) Reset = ~Reset;
	end

	function automatic bit touches(input platformT obj, input int halfX, input int halfY,
		input int x, input int y);
		int dx;
		int dy;
		dx = int'(obj.x) - x;
		dy = int'(obj.y) - (y + DoodleSize);
		touches = obj.active && dx <= halfX + DoodleSize && -dx <= halfX + DoodleSize
			&& dy <= halfY && -dy <= halfY;
	endfunction

	function automatic int launchAt(input int x, input int y);
		bit onPlat;
		onPlat = 1'b0;
		for (int i = 0; i < NumPlatforms; i++)
			onPlat = onPlat | touches(platforms[i], PlatHalfX, PlatHalfY, x, y);
		if (touches(rocketPos, RocketHalf, RocketHalf, x, y))
			launchAt = RocketLaunch;
		else if (touches(springPos, SpringHalf, SpringHalf, x, y))
			launchAt = SpringLaunch;
		else
			launchAt = onPlat ? PlatLaunch : 0;
	endfunction

	// one accepted tick of the model
	task automatic stepModel();
		int speed;
		expectT e;
		speed = launchAt(mX, mY);
		if (mV >= 0 && speed > 0)
			mV = -speed;
		else if (mV >= 0 && mY + DoodleSize >= FloorY)
			mV = -PlatLaunch;
		else
			mV = (mV + Gravity > MaxFall) ? MaxFall : mV + Gravity;
		mY = (mY + mV) & 1023;     // 10-bit screen coordinate
		case (keycode)
			KeyLeftA, KeyLeftB: mX = mX - StepX;
			KeyRightA, KeyRightB: mX = mX + StepX;
			default: mX = mX;
		endcase
		if (mX < WrapMargin)
			mX = ScreenXMax - WrapMargin;
		else if (mX > ScreenXMax - WrapMargin)
			mX = WrapMargin;
		if (!mOver && mY + DoodleSize >= FloorY && mScore > OverScore)
			mOver = 1'b1;
		if (mY < mBest)
		begin
			mScore = mScore + mBest - mY;
			mBest = mY;
		end
		e.rec.posX = coordT'(mX);
		e.rec.posY = coordT'(mY);
		e.rec.velY = velT'(mV);
		e.score = 20'(mScore);
		e.over = mOver;
		expQ.push_back(e);
	endtask

	always @(posedge Reset or posedge frameClk)
	begin
		if (frameClk)
		begin
			expQ.delete();
			mX = StartX;
			mY = StartY;
			mV = 0;
			mCredits = FifoDepth;
			mScore = 0;
			mBest = ScoreLine;
			mOver = 1'b0;
		end
		else
		begin
			if (frameValid && expQ.size() > 0)
				void'(expQ.pop_front());
			if (frameTick && mCredits > 0)
			begin
				mCredits = mCredits - 1;
				stepModel();
			end
			mCredits = mCredits + int'(frameValid);   // a credit comes back with each output
		end
		expCount = expQ.size();
		expHead = (expCount > 0) ? expQ[0] : '0;
	end

	resetQuiet: assert property (@(posedge Reset) frameClk |-> !frameValid && !gameOver
		&& score == '0)
		else
		begin
			errors++;
			$display("outputs not idle during reset at %0t", $time);
		end
	recordMatch: assert property (@(posedge Reset) disable iff (frameClk)
		frameValid |-> frameOut == expHead.rec)
		else
		begin
			errors++;
			$display("mismatch at %0t: frameOut expected %h got %h", $time,
				$sampled(expHead.rec), $sampled(frameOut));
		end
	scoreMatch: assert property (@(posedge Reset) disable iff (frameClk)
		frameValid |-> score == expHead.score)
		else
		begin
			errors++;
			$display("mismatch at %0t: score expected %0d got %0d", $time,
				$sampled(expHead.score), $sampled(score));
		end
	overMatch: assert property (@(posedge Reset) disable iff (frameClk)
		frameValid |-> gameOver == expHead.over)
		else
		begin
			errors++;
			$display("mismatch at %0t: gameOver expected %b got %b", $time,
				$sampled(expHead.over), $sampled(gameOver));
		end
	noExtraFrame: assert property (@(posedge Reset) disable iff (frameClk)
		frameValid |-> expCount > 0)
		else
		begin
			errors++;
			$display("frame sent with none expected at %0t", $time);
		end
	overSticky: assert property (@(posedge Reset) disable iff (frameClk) gameOver |=> gameOver)
		else
		begin
			errors++;
			$display("gameOver fell without reset at %0t", $time);
		end
	busyHolds: assert property (@(posedge Reset) disable iff (frameClk)
		renderBusy |=> !frameValid)
		else
		begin
			errors++;
			$display("frame sent while renderer busy at %0t", $time);
		end
	bufferBound: assert property (@(posedge Reset) disable iff (frameClk)
		dut0.fifo0.count <= FifoDepth)
		else
		begin
			errors++;
			$display("buffer holds more than %0d records at %0t", FifoDepth, $time);
		end
	tickDrop: assert property (@(posedge Reset) disable iff (frameClk)
		frameTick && mCredits == 0 |=> $stable(dut0.posY) && $stable(dut0.posX))
		else
		begin
			errors++;
			$display("tick without credit moved the figure at %0t", $time);
		end

	task automatic beginTest();
		@(negedge Reset);
		frameClk = 1'b1;
		frameTick = 1'b0;
		keycode = 8'd0;
		renderBusy = 1'b0;
		platforms = '0;
		springPos = '0;
		rocketPos = '0;
		repeat (8) @(negedge Reset);
		frameClk = 1'b0;
		errorsBefore = errors;
	endtask

	task automatic sendTicks(input int count, input bit randomKeys);
		logic [7:0] keyTable [5];
		keyTable = '{8'd0, 8'(KeyLeftA), 8'(KeyLeftB), 8'(KeyRightA), 8'(KeyRightB)};
		repeat (count)
		begin
			@(negedge Reset);
			if (randomKeys)
				keycode = keyTable[$unsigned($random(seed)) % 5];
			frameTick = 1'b1;
			@(negedge Reset);
			frameTick = 1'b0;
			repeat (TickGap - 2) @(negedge Reset);
		end
	endtask

	// ticks every other cycle against a renderer that stalls at random
	task automatic noisyRender(input int count);
		repeat (count)
		begin
			@(negedge Reset);
			frameTick = 1'b1;
			renderBusy = ($random(seed) % 2) != 0;
			@(negedge Reset);
			frameTick = 1'b0;
			renderBusy = ($random(seed) % 2) != 0;
		end
		renderBusy = 1'b0;
	endtask

	task automatic endTest(input int num, input string name);
		int waited;
		waited = 0;
		while (expCount != 0 && waited < DrainLimit)
		begin
			@(negedge Reset);
			waited++;
		end
		@(negedge Reset);
		if (expCount != 0)
		begin
			errors++;
			$display("records still pending %0d cycles after the last tick", DrainLimit);
		end
		if (errors == errorsBefore)
			passCount++;
		else
			failCount++;
		$display("test %0d %s: %s", num, name, (errors == errorsBefore) ? "ok" : "errors");
	endtask

	initial
	begin
		#(WatchCycles * ClkPeriod);
		$display("watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		seed = 32'h74cd_350f;
		errors = 0;
		passCount = 0;
		failCount = 0;
		frameClk = 1'b1;
		frameTick = 1'b0;
		keycode = 8'd0;
		renderBusy = 1'b0;
		platforms = '0;
		springPos = '0;
		rocketPos = '0;

		beginTest();
		sendTicks(1, 1'b0);
		endTest(1, "reset and first record");

		beginTest();
		sendTicks(60, 1'b0);                // falls to the ground and bounces
		endTest(2, "free fall");

		beginTest();
		platforms[0] = '{x: coordT'(StartX), y: coordT'(300), active: 1'b1};
		sendTicks(40, 1'b0);
		platforms[0].active = 1'b0;
		springPos = '{x: coordT'(StartX), y: coordT'(300), active: 1'b1};
		sendTicks(40, 1'b0);
		springPos.active = 1'b0;
		rocketPos = '{x: coordT'(StartX), y: coordT'(420), active: 1'b1};
		sendTicks(40, 1'b0);
		endTest(3, "contacts");

		beginTest();
		keycode = 8'(KeyLeftA);
		sendTicks(90, 1'b0);
		keycode = 8'(KeyRightB);
		sendTicks(90, 1'b0);
		sendTicks(40, 1'b1);
		endTest(4, "keys and wrap");

		beginTest();
		for (int i = 0; i < NumPlatforms; i++)
			platforms[i] = '{x: coordT'(300 + $unsigned($random(seed)) % 60),
				y: coordT'(120 + $unsigned($random(seed)) % 340), active: 1'b1};
		sendTicks(80, 1'b0);
		endTest(5, "score and game over");

		beginTest();
		renderBusy = 1'b1;
		sendTicks(10, 1'b0);                // only the buffered ones survive
		renderBusy = 1'b0;
		noisyRender(30);
		endTest(6, "render back-pressure");

		$display("tests passed %0d failed %0d, check errors %0d", passCount, failCount, errors);
		if (failCount == 0 && errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
